//--- logic/dsp_settings.svh
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// samples per clock on every DAC and ADC port
`define DSP_LANES 4

// one Q1.15 sample
`define DSP_SAMPLE_W 16

// envelope table, 32 entries
`define DSP_ENV_AW 5

// frequency table, 8 carriers
`define DSP_FREQ_AW 3

// acquisition buffer, 16 entries
`define DSP_ACQ_AW 4

// product scaling back to Q1.15
`define DSP_FRAC 15

`endif

//--- logic/dsp_pkg.sv
`include "dsp_settings.svh"

package dsp_pkg;

	typedef logic signed [`DSP_SAMPLE_W-1:0] sample_t;

	// x is cosine and y is sine when used as a carrier point
	typedef struct packed {
		sample_t x;
		sample_t y;
	} iq_t;

	typedef iq_t [`DSP_LANES-1:0] lane_iq_t;

	typedef lane_iq_t env_word_t;
	typedef lane_iq_t cossin_word_t;

	typedef sample_t [`DSP_LANES-1:0] dac_word_t;

	typedef struct packed {
		dac_word_t adc;  // upper half
		dac_word_t dac;
	} acq_word_t;

	typedef enum logic [2:0] {
		qdrv_env, qdrv_freq, rdrv_env, rdrv_freq, rdlo_env, rdlo_freq
	} table_id_t;

	typedef enum logic [1:0] {chan_qdrv, chan_rdrv, chan_rdlo} chan_t;

endpackage

//--- logic/wave_table.sv
`timescale 1ns/1ns

module wave_table #(
	parameter type entry_t = logic [127:0],
	parameter int AW = 5
) (
	input logic dspif,
	input logic we,
	input logic [AW-1:0] waddr,
	input entry_t wdata,
	input logic [AW-1:0] raddr,
	output entry_t rdata
);

	localparam int depth = 2 ** AW;

	// zero from configuration, host loads it before use
	entry_t mem [depth] = '{default: '0};

	always_ff @(posedge dspif) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// one clock read latency
	always_ff @(posedge dspif) begin
		rdata <= mem[raddr];
	end

	a_waddr_known: assert property (
		@(posedge dspif) we |-> !$isunknown(waddr)
	) else $error("wave_table: write with unknown address");

endmodule

//--- logic/element_calc.sv
`timescale 1ns/1ns
`include "dsp_settings.svh"

module element_calc
	import dsp_pkg::*;
(
	input logic dspif,
	input logic arst_n,
	input env_word_t env,
	input cossin_word_t carrier,
	input sample_t amp,
	output dac_word_t out_x,
	output dac_word_t out_y
);

	localparam int pw = 2 * `DSP_SAMPLE_W;

	for (genvar i = 0; i < `DSP_LANES; i++) begin : g_lane
		logic signed [pw-1:0] p_xc;
		logic signed [pw-1:0] p_ys;
		logic signed [pw-1:0] p_xs;
		logic signed [pw-1:0] p_yc;
		logic signed [pw-1:0] sum_x;
		logic signed [pw-1:0] sum_y;
		logic signed [pw-1:0] scl_x;
		logic signed [pw-1:0] scl_y;
		sample_t mx;
		sample_t my;
		sample_t ox;
		sample_t oy;

		// only bits up to 30 survive the shift, so a 32 bit wrap is enough
		assign sum_x = p_xc - p_ys;
		assign sum_y = p_xs + p_yc;
		assign scl_x = $signed(mx) * $signed(amp);
		assign scl_y = $signed(my) * $signed(amp);

		// stage 1, partial products
		always_ff @(posedge dspif or negedge arst_n) begin
			if (!arst_n) begin
				p_xc <= '0;
				p_ys <= '0;
				p_xs <= '0;
				p_yc <= '0;
			end else begin
				p_xc <= $signed(env[i].x) * $signed(carrier[i].x);
				p_ys <= $signed(env[i].y) * $signed(carrier[i].y);
				p_xs <= $signed(env[i].x) * $signed(carrier[i].y);
				p_yc <= $signed(env[i].y) * $signed(carrier[i].x);
			end
		end

		// stage 2, complex sum back to Q1.15
		always_ff @(posedge dspif or negedge arst_n) begin
			if (!arst_n) begin
				mx <= '0;
				my <= '0;
			end else begin
				mx <= sample_t'(sum_x >>> `DSP_FRAC);
				my <= sample_t'(sum_y >>> `DSP_FRAC);
			end
		end

		// stage 3, amplitude
		always_ff @(posedge dspif or negedge arst_n) begin
			if (!arst_n) begin
				ox <= '0;
				oy <= '0;
			end else begin
				ox <= sample_t'(scl_x >>> `DSP_FRAC);
				oy <= sample_t'(scl_y >>> `DSP_FRAC);
			end
		end

		assign out_x[i] = ox;
		assign out_y[i] = oy;
	end

endmodule

//--- logic/drive_channel.sv
`timescale 1ns/1ns
`include "dsp_settings.svh"

module drive_channel
	import dsp_pkg::*;
#(
	parameter chan_t CHAN = chan_qdrv
) (
	input logic dspif,
	input logic arst_n,
	input logic restart,
	input logic run,
	input logic tbl_we,
	input table_id_t tbl_sel,
	input logic [`DSP_ENV_AW-1:0] tbl_addr,
	input lane_iq_t tbl_wdata,
	input logic [`DSP_FREQ_AW-1:0] freq_sel,
	input sample_t amp,
	output dac_word_t dac,
	output dac_word_t dac_q
);

	// own table ids on the host select
	localparam table_id_t env_id = (CHAN == chan_qdrv) ? qdrv_env :
		(CHAN == chan_rdrv) ? rdrv_env : rdlo_env;
	localparam table_id_t freq_id = (CHAN == chan_qdrv) ? qdrv_freq :
		(CHAN == chan_rdrv) ? rdrv_freq : rdlo_freq;

	logic env_we;
	logic freq_we;
	logic [`DSP_ENV_AW-1:0] env_addr;
	env_word_t env_rd;
	cossin_word_t cossin_rd;
	dac_word_t calc_x;
	dac_word_t calc_y;

	assign env_we = tbl_we && (tbl_sel == env_id);
	assign freq_we = tbl_we && (tbl_sel == freq_id);

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			env_addr <= '0;
		end else if (restart) begin
			env_addr <= '0;
		end else if (run) begin
			env_addr <= env_addr + 1'b1;  // wraps at 32
		end
	end

	wave_table #(
		.entry_t(env_word_t),
		.AW(`DSP_ENV_AW)
	) u_env_tbl (
		.dspif(dspif),
		.we(env_we),
		.waddr(tbl_addr),
		.wdata(tbl_wdata),
		.raddr(env_addr),
		.rdata(env_rd)
	);

	// freq_sel goes straight to the read port so it lines up with the envelope
	wave_table #(
		.entry_t(cossin_word_t),
		.AW(`DSP_FREQ_AW)
	) u_freq_tbl (
		.dspif(dspif),
		.we(freq_we),
		.waddr(tbl_addr[`DSP_FREQ_AW-1:0]),
		.wdata(tbl_wdata),
		.raddr(freq_sel),
		.rdata(cossin_rd)
	);

	element_calc u_calc (
		.dspif(dspif),
		.arst_n(arst_n),
		.env(env_rd),
		.carrier(cossin_rd),
		.amp(amp),
		.out_x(calc_x),
		.out_y(calc_y)
	);

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			dac <= '0;
			dac_q <= '0;
		end else begin
			dac <= calc_x;
			dac_q <= calc_y;
		end
	end

	a_valid_table_sel: assert property (
		@(posedge dspif) disable iff (!arst_n)
		tbl_we |-> tbl_sel inside {qdrv_env, qdrv_freq, rdrv_env, rdrv_freq, rdlo_env, rdlo_freq}
	) else $error("drive_channel: table write with an undefined table id");

endmodule

//--- logic/acq_capture.sv
`timescale 1ns/1ns
`include "dsp_settings.svh"

module acq_capture
	import dsp_pkg::*;
(
	input logic dspif,
	input logic arst_n,
	input logic restart,
	input dac_word_t adc,
	input dac_word_t dac,
	input logic [`DSP_ACQ_AW-1:0] acq_raddr,
	output acq_word_t acq_rdata,
	output logic acq_full
);

	localparam int depth = 2 ** `DSP_ACQ_AW;

	acq_word_t mem [depth];
	dac_word_t adc_r;
	logic restart_r;
	logic [`DSP_ACQ_AW-1:0] waddr;
	logic locked;
	logic acq_we;

	assign acq_we = !locked;

	always_ff @(posedge dspif) begin
		adc_r <= adc;
	end

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			restart_r <= 1'b0;
		end else begin
			restart_r <= restart;
		end
	end

	// starts parked on the last entry with writes off, but not yet full
	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			waddr <= '1;
			locked <= 1'b1;
			acq_full <= 1'b0;
		end else if (restart_r) begin
			waddr <= '0;
			locked <= 1'b0;
			acq_full <= 1'b0;
		end else if (!locked) begin
			if (&waddr) begin
				locked <= 1'b1;  // hold at last address
				acq_full <= 1'b1;
			end else begin
				waddr <= waddr + 1'b1;
			end
		end
	end

	// adc from last edge beside the current dac word
	always_ff @(posedge dspif) begin
		if (acq_we) begin
			mem[waddr] <= '{adc: adc_r, dac: dac};
		end
	end

	always_ff @(posedge dspif) begin
		acq_rdata <= mem[acq_raddr];
	end

	a_no_write_when_full: assert property (
		@(posedge dspif) disable iff (!arst_n) acq_full |-> !acq_we
	) else $error("acq_capture: write while buffer full");

endmodule

//--- logic/dsp_core.sv
`timescale 1ns/1ns
`include "dsp_settings.svh"

module dsp_core
	import dsp_pkg::*;
(
	input logic dspif,
	input logic arst_n,
	input logic restart,
	input logic run,
	input sample_t amp,
	input logic tbl_we,
	input table_id_t tbl_sel,
	input logic [`DSP_ENV_AW-1:0] tbl_addr,
	input lane_iq_t tbl_wdata,
	input logic [`DSP_FREQ_AW-1:0] freq_sel_q,
	input logic [`DSP_FREQ_AW-1:0] freq_sel_r,
	input logic [`DSP_FREQ_AW-1:0] freq_sel_lo,
	input dac_word_t adc,
	input logic [`DSP_ACQ_AW-1:0] acq_raddr,
	output dac_word_t dac_q,
	output dac_word_t dac_r,
	output dac_word_t dac_lo,
	output dac_word_t dac_lo_q,
	output acq_word_t acq_rdata,
	output logic acq_full
);

	// qubit drive, quadrature unused
	drive_channel #(.CHAN(chan_qdrv)) u_qdrv (
		.dspif(dspif), .arst_n(arst_n), .restart(restart), .run(run),
		.tbl_we(tbl_we), .tbl_sel(tbl_sel), .tbl_addr(tbl_addr),
		.tbl_wdata(tbl_wdata), .freq_sel(freq_sel_q), .amp(amp),
		.dac(dac_q), .dac_q()
	);

	drive_channel #(.CHAN(chan_rdrv)) u_rdrv (
		.dspif(dspif), .arst_n(arst_n), .restart(restart), .run(run),
		.tbl_we(tbl_we), .tbl_sel(tbl_sel), .tbl_addr(tbl_addr),
		.tbl_wdata(tbl_wdata), .freq_sel(freq_sel_r), .amp(amp),
		.dac(dac_r), .dac_q()
	);

	// readout LO keeps both branches
	drive_channel #(.CHAN(chan_rdlo)) u_rdlo (
		.dspif(dspif), .arst_n(arst_n), .restart(restart), .run(run),
		.tbl_we(tbl_we), .tbl_sel(tbl_sel), .tbl_addr(tbl_addr),
		.tbl_wdata(tbl_wdata), .freq_sel(freq_sel_lo), .amp(amp),
		.dac(dac_lo), .dac_q(dac_lo_q)
	);

	acq_capture u_acq (
		.dspif(dspif),
		.arst_n(arst_n),
		.restart(restart),
		.adc(adc),
		.dac(dac_r),  // readout drive beside the adc
		.acq_raddr(acq_raddr),
		.acq_rdata(acq_rdata),
		.acq_full(acq_full)
	);

endmodule

//--- tb/dsp_tb.sv
`timescale 1ns/1ns
`include "dsp_settings.svh"

module dsp_tb
	import dsp_pkg::*;
();

	localparam int env_depth = 1 << `DSP_ENV_AW;
	localparam int freq_depth = 1 << `DSP_FREQ_AW;
	localparam int acq_depth = 1 << `DSP_ACQ_AW;
	localparam int q15_max = 22937;  // 0.7 in Q1.15

	logic dspif;
	logic arst_n;
	logic restart;
	logic run;
	sample_t amp;
	logic tbl_we;
	table_id_t tbl_sel;
	logic [`DSP_ENV_AW-1:0] tbl_addr;
	lane_iq_t tbl_wdata;
	logic [`DSP_FREQ_AW-1:0] freq_sel_q;
	logic [`DSP_FREQ_AW-1:0] freq_sel_r;
	logic [`DSP_FREQ_AW-1:0] freq_sel_lo;
	dac_word_t adc;
	logic [`DSP_ACQ_AW-1:0] acq_raddr;
	dac_word_t dac_q;
	dac_word_t dac_r;
	dac_word_t dac_lo;
	dac_word_t dac_lo_q;
	acq_word_t acq_rdata;
	logic acq_full;

	int mism_cnt;
	int fail_cnt;
	logic [15:0] adc_cnt;

	// reference model, channel index 0 qdrv, 1 rdrv, 2 rdlo
	lane_iq_t env_sh [3][env_depth] = '{default: '0};
	lane_iq_t freq_sh [3][freq_depth] = '{default: '0};
	lane_iq_t pipe [3][3];
	lane_iq_t sc [3];
	logic [`DSP_FREQ_AW-1:0] fs [3];
	logic [`DSP_ENV_AW-1:0] addr_m;
	int since;  // edges since restart was sampled
	dac_word_t adc_d;
	dac_word_t exp_x [3];
	dac_word_t exp_y [3];
	acq_word_t acq_m [acq_depth];
	logic acq_v [acq_depth];
	acq_word_t exp_rd;
	logic exp_rd_v;
	logic full_m;

	dsp_core DUT (.*);

	initial begin
		dspif = 1'b0;
		forever #5 dspif = ~dspif;
	end

	function automatic sample_t rand_q15(input int max);
		return sample_t'(int'($urandom_range(2 * max)) - max);
	endfunction

	function automatic lane_iq_t rand_word(input bit carrier);
		lane_iq_t w;
		for (int i = 0; i < `DSP_LANES; i++) begin
			if (carrier) begin
				w[i].x = rand_q15(q15_max);
				w[i].y = rand_q15(q15_max);
			end else begin
				w[i] = iq_t'($urandom);
			end
		end
		return w;
	endfunction

	// complex product, Q1.15 back to 16 bits
	function automatic lane_iq_t mix(input lane_iq_t env, input lane_iq_t car);
		lane_iq_t m;
		longint px;
		longint py;
		for (int i = 0; i < `DSP_LANES; i++) begin
			px = longint'(env[i].x) * longint'(car[i].x) - longint'(env[i].y) * longint'(car[i].y);
			py = longint'(env[i].x) * longint'(car[i].y) + longint'(env[i].y) * longint'(car[i].x);
			m[i].x = sample_t'(px >>> `DSP_FRAC);
			m[i].y = sample_t'(py >>> `DSP_FRAC);
		end
		return m;
	endfunction

	function automatic lane_iq_t scale(input lane_iq_t m, input sample_t a);
		lane_iq_t s;
		for (int i = 0; i < `DSP_LANES; i++) begin
			s[i].x = sample_t'((longint'(m[i].x) * longint'(a)) >>> `DSP_FRAC);
			s[i].y = sample_t'((longint'(m[i].y) * longint'(a)) >>> `DSP_FRAC);
		end
		return s;
	endfunction

	always @(posedge dspif) begin
		if (!arst_n) begin
			addr_m = '0;
			since = -1;
			full_m <= 1'b0;
			exp_rd_v <= 1'b0;
			for (int c = 0; c < 3; c++) begin
				sc[c] = '0;
				pipe[c] = '{default: '0};
				exp_x[c] <= '0;
				exp_y[c] <= '0;
			end
			for (int a = 0; a < acq_depth; a++) begin
				acq_v[a] = 1'b0;
			end
		end else begin
			exp_rd <= acq_m[acq_raddr];  // read sees the old entry
			exp_rd_v <= acq_v[acq_raddr];
			if (restart) begin
				since = 0;
			end else if (since >= 0 && since < 64) begin
				since++;
			end
			if (since == 1) begin
				full_m <= 1'b0;
			end
			// entry a lands at k+2+a beside the dac_r word of that clock
			if (since >= 2 && since < 2 + acq_depth) begin
				acq_m[since-2] = '{adc: adc_d, dac: exp_x[1]};
				acq_v[since-2] = 1'b1;
			end
			if (since == 1 + acq_depth) begin
				full_m <= 1'b1;
			end
			adc_d = adc;
			fs[0] = freq_sel_q;
			fs[1] = freq_sel_r;
			fs[2] = freq_sel_lo;
			for (int c = 0; c < 3; c++) begin
				for (int i = 0; i < `DSP_LANES; i++) begin
					exp_x[c][i] <= sc[c][i].x;
					exp_y[c][i] <= sc[c][i].y;
				end
				sc[c] = scale(pipe[c][2], amp);  // amp taken three clocks after the read
				pipe[c][2] = pipe[c][1];
				pipe[c][1] = pipe[c][0];
				pipe[c][0] = mix(env_sh[c][addr_m], freq_sh[c][fs[c]]);
			end
			if (restart) begin
				addr_m = '0;
			end else if (run) begin
				addr_m = addr_m + 1'b1;
			end
			if (tbl_we && int'(tbl_sel) % 2 == 0) begin
				env_sh[int'(tbl_sel) / 2][tbl_addr] = tbl_wdata;
			end else if (tbl_we) begin
				freq_sh[int'(tbl_sel) / 2][tbl_addr[`DSP_FREQ_AW-1:0]] = tbl_wdata;
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		mism_cnt++;
		$display("mismatch %s: got %0h expected %0h", name, got, exp);
	endtask

	a_dac_q: assert property (@(posedge dspif) disable iff (!arst_n) dac_q == exp_x[0])
		else report_mismatch("dac_q", $sampled(dac_q), $sampled(exp_x[0]));
	a_dac_r: assert property (@(posedge dspif) disable iff (!arst_n) dac_r == exp_x[1])
		else report_mismatch("dac_r", $sampled(dac_r), $sampled(exp_x[1]));
	a_dac_lo: assert property (@(posedge dspif) disable iff (!arst_n) dac_lo == exp_x[2])
		else report_mismatch("dac_lo", $sampled(dac_lo), $sampled(exp_x[2]));
	a_dac_lo_q: assert property (@(posedge dspif) disable iff (!arst_n) dac_lo_q == exp_y[2])
		else report_mismatch("dac_lo_q", $sampled(dac_lo_q), $sampled(exp_y[2]));
	a_acq_full: assert property (@(posedge dspif) disable iff (!arst_n) acq_full == full_m)
		else report_mismatch("acq_full", $sampled(acq_full), $sampled(full_m));
	a_acq_rdata: assert property (
		@(posedge dspif) disable iff (!arst_n) exp_rd_v |-> acq_rdata == exp_rd
	) else report_mismatch("acq_rdata", $sampled(acq_rdata), $sampled(exp_rd));

	a_reset_clear: assert property (
		@(posedge dspif) !arst_n |-> (dac_q == '0 && dac_r == '0 && dac_lo == '0
			&& dac_lo_q == '0 && !acq_full)
	) else begin
		fail_cnt++;
		$display("outputs not cleared while reset is held");
	end

	// ramp pattern, distinct per lane
	initial begin
		adc = '0;
		adc_cnt = '0;
		forever begin
			@(posedge dspif);
			for (int i = 0; i < `DSP_LANES; i++) begin
				adc[i] <= sample_t'(adc_cnt * 16'd7 + 16'(i) * 16'h1111);
			end
			adc_cnt <= adc_cnt + 16'd1;
		end
	end

	task automatic load_table(input table_id_t sel);
		int depth;
		depth = (sel inside {qdrv_env, rdrv_env, rdlo_env}) ? env_depth : freq_depth;
		for (int a = 0; a < depth; a++) begin
			@(posedge dspif);
			tbl_we <= 1'b1;
			tbl_sel <= sel;
			tbl_addr <= `DSP_ENV_AW'(a);
			tbl_wdata <= rand_word(depth == freq_depth);
		end
		@(posedge dspif);
		tbl_we <= 1'b0;
	endtask

	task automatic restart_run();
		@(posedge dspif);
		restart <= 1'b1;
		run <= 1'b1;
		@(posedge dspif);
		restart <= 1'b0;
		@(posedge dspif);  // acq_full drops here
	endtask

	task automatic wait_full(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge dspif);
			n++;
		end while (!acq_full && n < limit);
		if (!acq_full) begin
			fail_cnt++;
			$display("timeout waiting for the acquisition buffer to fill");
		end
	endtask

	task automatic read_back();
		for (int a = 0; a < acq_depth; a++) begin
			@(posedge dspif);
			acq_raddr <= `DSP_ACQ_AW'(a);
		end
		repeat (2) @(posedge dspif);
	endtask

	initial begin
		void'($urandom(32'h8cfa_3cec));
		mism_cnt = 0;
		fail_cnt = 0;
		arst_n = 1'b0;
		restart = 1'b0;
		run = 1'b0;
		amp = '0;
		tbl_we = 1'b0;
		tbl_sel = qdrv_env;
		tbl_addr = '0;
		tbl_wdata = '0;
		freq_sel_q = '0;
		freq_sel_r = '0;
		freq_sel_lo = '0;
		acq_raddr = '0;
		repeat (5) @(posedge dspif);
		arst_n <= 1'b1;
		repeat (4) @(posedge dspif);
		load_table(qdrv_env);
		load_table(qdrv_freq);
		load_table(rdrv_env);
		load_table(rdrv_freq);
		load_table(rdlo_env);
		load_table(rdlo_freq);
		amp <= sample_t'($urandom_range(q15_max));
		freq_sel_q <= `DSP_FREQ_AW'($urandom);
		freq_sel_r <= `DSP_FREQ_AW'($urandom);
		freq_sel_lo <= `DSP_FREQ_AW'($urandom);
		restart_run();
		wait_full(40);
		read_back();
		load_table(rdrv_env);  // other channels must not move
		freq_sel_r <= freq_sel_r + 1'b1;
		repeat (12) @(posedge dspif);
		run <= 1'b0;
		repeat (6) @(posedge dspif);
		run <= 1'b1;
		amp <= sample_t'($urandom_range(q15_max));
		repeat (12) @(posedge dspif);
		restart_run();
		wait_full(40);
		read_back();
		repeat (8) @(posedge dspif);
		$display("checks done: %0d mismatches, %0d other errors", mism_cnt, fail_cnt);
		if (mism_cnt == 0 && fail_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+logic
logic/dsp_pkg.sv
logic/wave_table.sv
logic/element_calc.sv
logic/drive_channel.sv
logic/acq_capture.sv
logic/dsp_core.sv
tb/dsp_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dsp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module dsp_tb -f all.f -o dsp_tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/dsp_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
